//--- flist.f
+incdir+logic
logic/jpack_bus_pkg.sv
logic/jpack_ctl_pkg.sv
logic/jpack_req_if.sv
logic/jpack_fatal_src.sv
logic/jpack_fatal_lane.sv
logic/jpack_req_merge.sv
logic/jpack_snoop_queue.sv
logic/jpack_out_gen.sv
logic/jpack_top.sv
bench/jpack_properties.sv
bench/jpack_tb.sv

//--- Bender.yml
package:
  name: jpack

sources:
  - include_dirs:
      - logic
    files:
      - logic/jpack_bus_pkg.sv
      - logic/jpack_ctl_pkg.sv
      - logic/jpack_req_if.sv
      - logic/jpack_fatal_src.sv
      - logic/jpack_fatal_lane.sv
      - logic/jpack_req_merge.sv
      - logic/jpack_snoop_queue.sv
      - logic/jpack_out_gen.sv
      - logic/jpack_top.sv
      - target: simulation
        files:
          - bench/jpack_properties.sv
          - bench/jpack_tb.sv

//--- bench/jpack_tb.sv
// Self-checking testbench for the J_PACK generator.
// A cycle model built from the bus rules predicts every code; launches are
// kept well below counter saturation so no acknowledgement is lost.
`timescale 1ns/1ns
`include "jpack_defs.svh"

module jpack_tb;

  // Launch gate on the modeled pending count.
  localparam int SNOOP_CAP = 12;

  logic clk = 1'b0;
  logic rst;
  logic snp_launch;
  logic aok_off, aok_on, dok_off, dok_on;
  logic csr_fatal;
  jpack_ctl_pkg::bank_req_t bank_req;
  logic fe_enb;
  logic tx_en_early;
  jpack_bus_pkg::jpack_code_t j_pack0, j_pack1;
  logic j_pack0_en, j_pack1_en;

  // Reference model state from the bank edge stage through the generator.
  jpack_ctl_pkg::bank_req_t m_prev, m_new, m_caught, m_held;
  logic m_tx, m_fe, m_fatal, m_deq;
  int m_burst;
  int m_count;
  jpack_bus_pkg::jpack_code_t m_code;

  // Scoreboard.
  logic checking = 1'b0;
  int n_launch = 0;
  int n_cohack = 0;
  int rnd;

  always #5 clk = ~clk;

  jpack_top jpack_top_i (.*);

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_code(input string name, input jpack_bus_pkg::jpack_code_t got,
                            input jpack_bus_pkg::jpack_code_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_stop($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Failures recorded so far by the bound assertions.
  function automatic int bound_failures();
    return jpack_top_i.out_gen_i.props_i.fail_count +
           jpack_top_i.snoop_queue_i.props_i.fail_count;
  endfunction

  // One stimulus cycle. Flow bits are aok_off, dok_off, aok_on, dok_on.
  task automatic apply_inputs(input logic snp, input logic [3:0] flow, input logic csr,
                              input jpack_ctl_pkg::bank_req_t bank, input logic fe,
                              input logic txe);
    @(posedge clk);
    snp_launch  <= snp;
    aok_off     <= flow[0];
    dok_off     <= flow[1];
    aok_on      <= flow[2];
    dok_on      <= flow[3];
    csr_fatal   <= csr;
    bank_req    <= bank;
    fe_enb      <= fe;
    tx_en_early <= txe;
  endtask

  task automatic idle_inputs(input int cycles, input logic fe);
    repeat (cycles) apply_inputs(1'b0, 4'h0, 1'b0, '0, fe, 1'b0);
  endtask

  // Finds the next DOK_ON burst and measures it; inputs stay quiet meanwhile.
  task automatic wait_burst(input int limit);
    int waited;
    int run;
    waited = 0;
    run = 0;
    @(negedge clk);
    while (j_pack0 != jpack_bus_pkg::DOK_ON) begin
      if (waited == limit) begin
        fail_stop("timeout waiting for a DOK_ON burst");
      end
      @(negedge clk);
      waited++;
    end
    while (j_pack0 == jpack_bus_pkg::DOK_ON && run <= `JPACK_FATAL_LEN) begin
      run++;
      @(negedge clk);
    end
    check_count("dok_on_run", run, `JPACK_FATAL_LEN);
  endtask

  // Model steps once per clock through priority, burst, count and bank catching.
  always @(posedge clk) begin
    if (rst) begin
      m_prev = '0;
      m_new = '0;
      m_caught = '0;
      m_held = '0;
      m_tx = 1'b0;
      m_fe = 1'b0;
      m_burst = 0;
      m_count = 0;
      m_code = jpack_bus_pkg::IDLE;
    end else begin
      m_fatal = csr_fatal | ((|m_held) & m_fe);
      m_deq = 1'b0;
      // Burst cycles after the first ignore every request.
      if (m_burst > 0) begin
        m_code = jpack_bus_pkg::DOK_ON;
        m_burst--;
      end else if (m_fatal) begin
        m_code = jpack_bus_pkg::DOK_ON;
        m_burst = `JPACK_FATAL_LEN - 1;
      end else if (aok_off) begin
        m_code = jpack_bus_pkg::AOK_OFF;
      end else if (dok_off) begin
        m_code = jpack_bus_pkg::DOK_OFF;
      end else if (aok_on) begin
        m_code = jpack_bus_pkg::AOK_ON;
      end else if (dok_on) begin
        m_code = jpack_bus_pkg::DOK_ON;
      end else if (m_count > 0) begin
        m_code = jpack_bus_pkg::COHACK;
        m_deq = 1'b1;
      end else begin
        m_code = jpack_bus_pkg::IDLE;
      end
      if (snp_launch) begin
        n_launch++;
      end
      // Saturating count where a launch and an ack together cancel.
      if (snp_launch && !m_deq && m_count < (1 << `JPACK_SNOOP_W) - 1) begin
        m_count++;
      end else if (m_deq && !snp_launch) begin
        m_count--;
      end
      // Bank path is updated oldest stage first.
      m_held = m_tx ? m_caught : '0;
      m_caught = m_new | (m_caught & ~{`JPACK_NUM_BANK{m_tx}});
      m_new = bank_req & ~m_prev;
      m_prev = bank_req;
      m_tx = tx_en_early;
      m_fe = fe_enb;
    end
  end

  // Both lanes are compared with the model in every cycle after reset.
  always @(negedge clk) begin
    if (checking) begin
      check_code("j_pack0", j_pack0, m_code);
      check_code("j_pack1", j_pack1, m_code);
      check_bit("j_pack0_en", j_pack0_en, 1'b1);
      check_bit("j_pack1_en", j_pack1_en, 1'b1);
      if (bound_failures() != 0) begin
        fail_stop("a bound assertion failed");
      end
      if (j_pack0 == jpack_bus_pkg::COHACK) begin
        n_cohack++;
      end
    end
  end

  initial begin
    int waited;
    rnd = $urandom(32'hf33f);
    rst = 1'b1;
    snp_launch = 1'b0;
    aok_off = 1'b0;
    aok_on = 1'b0;
    dok_off = 1'b0;
    dok_on = 1'b0;
    csr_fatal = 1'b0;
    bank_req = '0;
    fe_enb = 1'b0;
    tx_en_early = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    checking = 1'b1;
    // Mixed traffic with occasional CSR and bank fatal requests.
    repeat (400) begin
      @(negedge clk);
      rnd = $urandom;
      apply_inputs(rnd[8] & rnd[9] & (m_count < SNOOP_CAP),
                   rnd[3:0] & rnd[7:4] & {4{rnd[25]}}, rnd[15:10] == 6'h0,
                   rnd[16 +: `JPACK_NUM_BANK] & {`JPACK_NUM_BANK{rnd[20] & rnd[21]}},
                   1'b1, rnd[22] & rnd[23] & rnd[24]);
    end
    // CSR fatal on a quiet bus.
    idle_inputs(10, 1'b1);
    apply_inputs(1'b0, 4'h0, 1'b1, '0, 1'b1, 1'b0);
    idle_inputs(1, 1'b1);
    wait_burst(4);
    // Bank request released by the next transmit enable.
    rnd = $urandom;
    apply_inputs(1'b0, 4'h0, 1'b0, {rnd[0 +: `JPACK_NUM_BANK-1], 1'b1}, 1'b1, 1'b0);
    idle_inputs(1 + rnd[9:8], 1'b1);
    apply_inputs(1'b0, 4'h0, 1'b0, '0, 1'b1, 1'b1);
    idle_inputs(1, 1'b1);
    wait_burst(8);
    // With the bank path disabled the model expects no burst.
    idle_inputs(2, 1'b0);
    apply_inputs(1'b0, 4'h0, 1'b0, {rnd[4 +: `JPACK_NUM_BANK-1], 1'b1}, 1'b0, 1'b0);
    idle_inputs(2, 1'b0);
    apply_inputs(1'b0, 4'h0, 1'b0, '0, 1'b0, 1'b1);
    idle_inputs(8, 1'b0);
    // Drain outstanding acknowledgements.
    waited = 0;
    @(negedge clk);
    while (m_count != 0) begin
      if (waited == 40) begin
        fail_stop("timeout waiting for the snoop count to drain");
      end
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    check_count("cohack_total", n_cohack, n_launch);
    if (bound_failures() != 0) begin
      fail_stop("bound assertions failed during the run");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

//--- bench/jpack_properties.sv
// Concurrent checks bound into the generator and the snoop queue.
// Each instance counts its own failures for the end-of-run summary.
`timescale 1ns/1ns

module jpack_properties (
  input logic                       clk,
  input logic                       rst,
  input jpack_ctl_pkg::gen_state_t  state,
  input jpack_bus_pkg::jpack_code_t j_pack,
  input logic                       dequeue,
  input logic                       pending,
  input logic                       overflow
);

  // Failed assertions in this instance.
  int fail_count = 0;

  // DOK_ON on entry to FATAL2 and in each burst state after it.
  a_fatal_burst: assert property (@(posedge clk) disable iff (rst)
    state == jpack_ctl_pkg::FATAL2 |-> j_pack == jpack_bus_pkg::DOK_ON
    ##1 (state == jpack_ctl_pkg::FATAL3 && j_pack == jpack_bus_pkg::DOK_ON)
    ##1 (state == jpack_ctl_pkg::FATAL4 && j_pack == jpack_bus_pkg::DOK_ON)
    ##1 (state == jpack_ctl_pkg::IDLE && j_pack == jpack_bus_pkg::DOK_ON))
  else begin
    fail_count++;
    $error("fatal burst is not four DOK_ON cycles");
  end

  // An acknowledgement goes out only for a launch still waiting.
  a_dequeue_pending: assert property (@(posedge clk) disable iff (rst) dequeue |-> pending)
  else begin
    fail_count++;
    $error("dequeue without a pending acknowledgement");
  end

  // A launch at full count would be dropped.
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) !overflow)
  else begin
    fail_count++;
    $error("snoop launch while the count is full");
  end

endmodule

// Bound in the generator, which has no counter.
bind jpack_out_gen jpack_properties props_i (
  .clk(clk), .rst(rst), .state(state), .j_pack(j_pack),
  .dequeue(dequeue), .pending(pending), .overflow(1'b0)
);

// Bound in the counter, which never runs a burst.
bind jpack_snoop_queue jpack_properties props_i (
  .clk(clk), .rst(rst), .state(jpack_ctl_pkg::IDLE), .j_pack(jpack_bus_pkg::IDLE),
  .dequeue(dequeue), .pending(pending), .overflow(enqueue & full)
);

//--- logic/jpack_top.sv
// J_PACK packet-out generator top level.
// Single clock domain; tx_en_early only paces bank fatal release.
// Both output lanes carry the same code, enables are always on.
`timescale 1ns/1ns
`include "jpack_defs.svh"

module jpack_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       snp_launch,
  input  logic                       aok_off,
  input  logic                       aok_on,
  input  logic                       dok_off,
  input  logic                       dok_on,
  input  logic                       csr_fatal,
  input  jpack_ctl_pkg::bank_req_t   bank_req,
  input  logic                       fe_enb,
  input  logic                       tx_en_early,
  output jpack_bus_pkg::jpack_code_t j_pack0,
  output logic                       j_pack0_en,
  output jpack_bus_pkg::jpack_code_t j_pack1,
  output logic                       j_pack1_en
);

  // Bank fatal path.
  jpack_ctl_pkg::bank_req_t   new_req;
  logic                       tx_en;
  logic [`JPACK_NUM_BANK-1:0] fatal_pulse;

  // Snoop queue handshake.
  logic pending;
  logic dequeue;

  // Generator output.
  jpack_bus_pkg::jpack_code_t j_pack;

  jpack_req_if req_if ();

  jpack_fatal_src fatal_src_i (
    .clk         (clk),
    .rst         (rst),
    .bank_req    (bank_req),
    .tx_en_early (tx_en_early),
    .new_req     (new_req),
    .tx_en       (tx_en)
  );

  // One catcher per bank.
  for (genvar i = 0; i < `JPACK_NUM_BANK; i++) begin : g_lane
    jpack_fatal_lane fatal_lane_i (
      .clk         (clk),
      .rst         (rst),
      .tx_en       (tx_en),
      .new_req     (new_req[i]),
      .fatal_pulse (fatal_pulse[i])
    );
  end

  jpack_req_merge req_merge_i (
    .clk         (clk),
    .rst         (rst),
    .fatal_pulse (fatal_pulse),
    .csr_fatal   (csr_fatal),
    .fe_enb      (fe_enb),
    .aok_off     (aok_off),
    .aok_on      (aok_on),
    .dok_off     (dok_off),
    .dok_on      (dok_on),
    .req         (req_if.src)
  );

  jpack_snoop_queue snoop_queue_i (
    .clk     (clk),
    .rst     (rst),
    .enqueue (snp_launch),
    .dequeue (dequeue),
    .pending (pending)
  );

  jpack_out_gen out_gen_i (
    .clk     (clk),
    .rst     (rst),
    .req     (req_if.dst),
    .pending (pending),
    .dequeue (dequeue),
    .j_pack  (j_pack)
  );

  // Mirrored lanes.
  assign j_pack0    = j_pack;
  assign j_pack1    = j_pack;
  assign j_pack0_en = 1'b1;
  assign j_pack1_en = 1'b1;

endmodule

//--- logic/jpack_out_gen.sv
// J_PACK code generator.
// One code per cycle, chosen by fixed priority and registered.
// Requests seen while a fatal burst is running are dropped.
`timescale 1ns/1ns

module jpack_out_gen (
  input  logic                     clk,
  input  logic                     rst,
  jpack_req_if.dst                 req,
  input  logic                     pending,
  output logic                     dequeue,
  output jpack_bus_pkg::jpack_code_t j_pack
);

  // Current and next generator state.
  jpack_ctl_pkg::gen_state_t state;
  jpack_ctl_pkg::gen_state_t next_state;

  // Code to register for the next cycle.
  jpack_bus_pkg::jpack_code_t next_code;

  // Next-state and output decode.
  // Priority: fatal, aok_off, dok_off, aok_on, dok_on, cohack.
  always_comb begin
    next_state = state;
    next_code  = jpack_bus_pkg::IDLE;
    dequeue    = 1'b0;
    case (state)
      jpack_ctl_pkg::IDLE: begin
        if (req.fatal) begin
          // First of the DOK_ON burst.
          next_state = jpack_ctl_pkg::FATAL2;
          next_code  = jpack_bus_pkg::DOK_ON;
        end else if (req.aok_off) begin
          next_code = jpack_bus_pkg::AOK_OFF;
        end else if (req.dok_off) begin
          next_code = jpack_bus_pkg::DOK_OFF;
        end else if (req.aok_on) begin
          next_code = jpack_bus_pkg::AOK_ON;
        end else if (req.dok_on) begin
          next_code = jpack_bus_pkg::DOK_ON;
        end else if (pending) begin
          // Lowest priority, pop one acknowledgement.
          next_code = jpack_bus_pkg::COHACK;
          dequeue   = 1'b1;
        end
      end
      // Rest of the burst, inputs ignored.
      jpack_ctl_pkg::FATAL2: begin
        next_state = jpack_ctl_pkg::FATAL3;
        next_code  = jpack_bus_pkg::DOK_ON;
      end
      jpack_ctl_pkg::FATAL3: begin
        next_state = jpack_ctl_pkg::FATAL4;
        next_code  = jpack_bus_pkg::DOK_ON;
      end
      jpack_ctl_pkg::FATAL4: begin
        next_state = jpack_ctl_pkg::IDLE;
        next_code  = jpack_bus_pkg::DOK_ON;
      end
      default: begin
        next_state = jpack_ctl_pkg::IDLE;
      end
    endcase
  end

  // State register.
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= jpack_ctl_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Output register, IDLE out of reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      j_pack <= jpack_bus_pkg::IDLE;
    end else begin
      j_pack <= next_code;
    end
  end

endmodule

//--- logic/jpack_snoop_queue.sv
// Count of snoop launches still waiting for a COHACK.
// Saturates at full; a launch at full count is dropped.
// Enqueue and dequeue in the same cycle leave the count unchanged.
`timescale 1ns/1ns
`include "jpack_defs.svh"

module jpack_snoop_queue (
  input  logic clk,
  input  logic rst,
  input  logic enqueue,
  input  logic dequeue,
  output logic pending
);

  // Outstanding acknowledgements.
  logic [`JPACK_SNOOP_W-1:0] count;

  // Count limits.
  logic full;
  logic empty;

  assign full  = &count;
  assign empty = (count == '0);

  // Up/down counter.
  // Both at once is a no-op.
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (enqueue && !dequeue && !full) begin
      count <= count + 1'b1;
    end else if (dequeue && !enqueue && !empty) begin
      count <= count - 1'b1;
    end
  end

  // Head of queue valid.
  assign pending = !empty;

endmodule

//--- logic/jpack_req_merge.sv
// Collects all request sources into the generator's request interface.
// Bank pulses count only while fe_enb is set; CSR fatal is never gated.
// fe_enb is a static configuration bit and is sampled once per cycle.
`timescale 1ns/1ns
`include "jpack_defs.svh"

module jpack_req_merge (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`JPACK_NUM_BANK-1:0] fatal_pulse,
  input  logic                       csr_fatal,
  input  logic                       fe_enb,
  input  logic                       aok_off,
  input  logic                       aok_on,
  input  logic                       dok_off,
  input  logic                       dok_on,
  jpack_req_if.src                   req
);

  // Registered copy of the fatal enable.
  logic fe_enb_q;

  // Any bank asking for fatal this cycle.
  logic bank_fatal;

  // Configuration bit, off out of reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      fe_enb_q <= 1'b0;
    end else begin
      fe_enb_q <= fe_enb;
    end
  end

  assign bank_fatal = |fatal_pulse;

  // Fatal only needs a pulse, the generator always sees it when idle.
  assign req.fatal = csr_fatal | (bank_fatal & fe_enb_q);

  // Flow control goes straight through.
  assign req.aok_off = aok_off;
  assign req.dok_off = dok_off;
  assign req.aok_on  = aok_on;
  assign req.dok_on  = dok_on;

endmodule

//--- logic/jpack_fatal_lane.sv
// Pulse catcher for one bank's fatal request.
// The request is held until the next tx_en, then released as one pulse.
// A new request in the same cycle as tx_en is kept for the next tx_en.
`timescale 1ns/1ns

module jpack_fatal_lane (
  input  logic clk,
  input  logic rst,
  input  logic tx_en,
  input  logic new_req,
  output logic fatal_pulse
);

  // Catcher, set by a new request.
  logic caught;

  // Holding stage, loaded on tx_en.
  logic held;

  // Set wins over clear.
  // Cleared once tx_en has moved it on.
  always_ff @(posedge clk) begin
    if (rst) begin
      caught <= 1'b0;
    end else if (new_req) begin
      caught <= 1'b1;
    end else if (tx_en) begin
      caught <= 1'b0;
    end
  end

  // Copy the catcher on tx_en only; otherwise no pulse.
  always_ff @(posedge clk) begin
    if (rst) begin
      held <= 1'b0;
    end else begin
      held <= tx_en & caught;
    end
  end

  // One cycle after a capture that found the catcher set.
  assign fatal_pulse = held;

endmodule

//--- logic/jpack_fatal_src.sv
// Front end of the bank fatal path.
// Bank requests are sampled on clk; only rising edges produce a request.
// tx_en is tx_en_early delayed by one cycle.
`timescale 1ns/1ns

module jpack_fatal_src (
  input  logic                    clk,
  input  logic                    rst,
  input  jpack_ctl_pkg::bank_req_t bank_req,
  input  logic                    tx_en_early,
  output jpack_ctl_pkg::bank_req_t new_req,
  output logic                    tx_en
);

  // Last sampled request level, for edge detection.
  jpack_ctl_pkg::bank_req_t bank_prev;

  // Rising edge detect per bank, registered.
  // A bank held high produces a single pulse.
  always_ff @(posedge clk) begin
    if (rst) begin
      bank_prev <= '0;
      new_req   <= '0;
    end else begin
      bank_prev <= bank_req;
      new_req   <= bank_req & ~bank_prev;
    end
  end

  // Last stage of the transmit enable distribution.
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_en <= 1'b0;
    end else begin
      tx_en <= tx_en_early;
    end
  end

endmodule

//--- logic/jpack_req_if.sv
// Request strobes from the merge block to the generator.
// All signals are one-cycle strobes with no handshake.
`timescale 1ns/1ns

interface jpack_req_if;

  // Flow control requests.
  logic aok_off;
  logic dok_off;
  logic aok_on;
  logic dok_on;

  // Fatal request, already gated and combined.
  logic fatal;

  // Driving side.
  modport src (
    output aok_off, dok_off, aok_on, dok_on, fatal
  );

  // Receiving side.
  modport dst (
    input aok_off, dok_off, aok_on, dok_on, fatal
  );

endinterface

//--- logic/jpack_ctl_pkg.sv
// Internal control types of the J_PACK generator.
// The state encoding assumes a four-cycle fatal burst.
`include "jpack_defs.svh"

package jpack_ctl_pkg;

  // Generator states.
  // FATAL2..FATAL4 hold off all requests while DOK_ON repeats.
  typedef enum logic [1:0] {
    IDLE   = 2'h0,
    FATAL2 = 2'h1,
    FATAL3 = 2'h2,
    FATAL4 = 2'h3
  } gen_state_t;

  // One request bit per cache bank.
  typedef logic [`JPACK_NUM_BANK-1:0] bank_req_t;

endpackage

//--- logic/jpack_bus_pkg.sv
// External J_PACK bus encoding.
// Codes are 3 bits; unused encodings are never driven.
package jpack_bus_pkg;

  // Code driven on each J_PACK lane every cycle.
  // IDLE is sent whenever nothing else is pending.
  typedef enum logic [2:0] {
    IDLE    = 3'h0,
    AOK_OFF = 3'h1,
    AOK_ON  = 3'h2,
    DOK_OFF = 3'h3,
    DOK_ON  = 3'h4,
    COHACK  = 3'h5
  } jpack_code_t;

endpackage

//--- logic/jpack_defs.svh
// Sizing constants for the J_PACK packet-out generator.
// The generator state machine is written for a four-cycle fatal burst;
// changing JPACK_FATAL_LEN alone does not lengthen it.
`ifndef JPACK_DEFS_SVH
`define JPACK_DEFS_SVH

// Number of cache banks that may request a fatal DOK burst.
`define JPACK_NUM_BANK 4

// Width of the pending snoop acknowledgement counter.
// Holds at most 2**W - 1 outstanding acknowledgements.
`define JPACK_SNOOP_W 4

// Consecutive DOK_ON cycles that signal a fatal error.
`define JPACK_FATAL_LEN 4

`endif
